/* buf_pkg.sv */
`default_nettype none

`include "fifo_settings.svh"

package buf_pkg;

	// one stored byte.
	typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

	// fill count, also used for the thresholds.
	typedef logic [`FIFO_CNT_WIDTH-1:0] count_t;

	typedef logic [`WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	// master side of a classic cycle.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	// slave side of a classic cycle.
	typedef struct packed {
		logic ack;
		wb_dat_t dat;
	} wb_rsp_t;

	// field order matches status bits 3:0.
	typedef struct packed {
		logic full;
		logic a_full;
		logic empty;
		logic a_empty;
	} fifo_flags_t;

	typedef struct packed {
		count_t a_full_thr;
		count_t a_empty_thr;
	} thr_t;

	typedef enum logic {
		idle,
		ack_phase
	} bus_state_e;

endpackage

`default_nettype wire

/* buf_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fifo_settings.svh"

module buf_regs (
	input wire clk,
	input wire rst_n,

	input wire buf_pkg::wb_req_t wb_req_i,
	output buf_pkg::wb_rsp_t wb_rsp_o,

	input wire buf_pkg::fifo_flags_t flags_i,
	input wire buf_pkg::count_t count_i,
	input wire buf_pkg::data_t head_data_i,
	input wire overflow_i,

	output buf_pkg::thr_t thr_o,
	output logic pop_o,
	output logic irq_o
);

	// interrupt enable bits.
	localparam int IRQ_NOT_EMPTY = 0;
	localparam int IRQ_A_FULL = 1;
	localparam int IRQ_OVERFLOW = 2;

	// sticky overflow position in status, also the clear bit on writes.
	localparam int STAT_OVF_BIT = 4;

	buf_pkg::bus_state_e state_q;

	logic accept;
	logic wr_acc;
	logic rd_acc;
	logic ovf_clear;

	buf_pkg::wb_dat_t rd_word;
	buf_pkg::wb_dat_t rsp_dat_q;

	buf_pkg::thr_t thr_q;
	logic [2:0] irq_en_q;
	logic ovf_q;
	logic [7:0] drop_cnt_q;

	// a request is taken only from idle; the held request is ignored in ack_phase.
	assign accept = (state_q == buf_pkg::idle) & wb_req_i.cyc & wb_req_i.stb;
	assign wr_acc = accept & wb_req_i.we;
	assign rd_acc = accept & ~wb_req_i.we;

	// pops on the ack edge; the fifo drops it when empty.
	assign pop_o = rd_acc & (wb_req_i.adr == `REG_DATA);

	assign ovf_clear = wr_acc & (wb_req_i.adr == `REG_STATUS) & wb_req_i.dat[STAT_OVF_BIT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= buf_pkg::idle;
		end else begin
			case (state_q)
				buf_pkg::idle: begin
					if (accept) begin
						state_q <= buf_pkg::ack_phase;
					end
				end
				buf_pkg::ack_phase: begin
					state_q <= buf_pkg::idle;
				end
				default: begin
					state_q <= buf_pkg::idle;
				end
			endcase
		end
	end

	always_comb begin
		rd_word = '0;
		case (wb_req_i.adr)
			`REG_DATA: begin
				rd_word[7:0] = head_data_i;
			end
			`REG_STATUS: begin
				rd_word[3:0] = flags_i;
				rd_word[STAT_OVF_BIT] = ovf_q;
				rd_word[11:8] = count_i;
				rd_word[23:16] = drop_cnt_q;
			end
			`REG_THRESH: begin
				rd_word[3:0] = thr_q.a_full_thr;
				rd_word[11:8] = thr_q.a_empty_thr;
			end
			`REG_IRQ_EN: begin
				rd_word[2:0] = irq_en_q;
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	// read word is latched with the head byte as it was before the pop.
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			rsp_dat_q <= rd_word;
		end
	end

	assign wb_rsp_o = '{ack: (state_q == buf_pkg::ack_phase), dat: rsp_dat_q};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			thr_q.a_full_thr <= buf_pkg::count_t'(`FIFO_A_FULL_THR_DEF);
			thr_q.a_empty_thr <= buf_pkg::count_t'(`FIFO_A_EMPTY_THR_DEF);
			irq_en_q <= '0;
		end else if (wr_acc) begin
			if (wb_req_i.adr == `REG_THRESH) begin
				thr_q.a_full_thr <= wb_req_i.dat[3:0];
				thr_q.a_empty_thr <= wb_req_i.dat[11:8];
			end
			if (wb_req_i.adr == `REG_IRQ_EN) begin
				irq_en_q <= wb_req_i.dat[2:0];
			end
		end
	end

	assign thr_o = thr_q;

	// clear wins over a drop in the same cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ovf_q <= 1'b0;
			drop_cnt_q <= '0;
		end else if (ovf_clear) begin
			ovf_q <= 1'b0;
			drop_cnt_q <= '0;
		end else if (overflow_i) begin
			ovf_q <= 1'b1;
			if (drop_cnt_q != 8'hff) begin
				drop_cnt_q <= drop_cnt_q + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_o <= 1'b0;
		end else begin
			irq_o <= (irq_en_q[IRQ_NOT_EMPTY] & ~flags_i.empty) |
				(irq_en_q[IRQ_A_FULL] & flags_i.a_full) |
				(irq_en_q[IRQ_OVERFLOW] & ovf_q);
		end
	end

	// the master holds the request until ack, so ack never outlives it.
	ack_within_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb)
	) else $error("buf_regs: ack without an active request");

endmodule

`default_nettype wire

/* fifo_settings.svh */
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// stored byte width.
`define FIFO_DATA_WIDTH 8

// number of entries and bits needed to hold a count from 0 to the depth.
`define FIFO_DEPTH 8
`define FIFO_CNT_WIDTH 4

// reset values of the programmable almost flags.
`define FIFO_A_FULL_THR_DEF 6
`define FIFO_A_EMPTY_THR_DEF 2

// wishbone word address width.
`define WB_ADR_WIDTH 2

// register word addresses, sized to the address width.
`define REG_DATA 2'd0
`define REG_STATUS 2'd1
`define REG_THRESH 2'd2
`define REG_IRQ_EN 2'd3

`endif

/* project.f */
+incdir+.
buf_pkg.sv
sync_fifo.sv
buf_regs.sv
rx_buffer_top.sv
tb_rx_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the rx buffer testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator is not on the PATH"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f project.f --top-module tb_rx_buffer -o tb_rx_buffer
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_rx_buffer)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1

/* rx_buffer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_buffer_top (
	input wire clk,
	input wire rst_n,

	// byte stream, no back-pressure.
	input wire in_valid_i,
	input wire buf_pkg::data_t in_data_i,

	input wire buf_pkg::wb_req_t wb_req_i,
	output buf_pkg::wb_rsp_t wb_rsp_o,

	output logic irq_o
);

	buf_pkg::fifo_flags_t flags;
	buf_pkg::count_t count;
	buf_pkg::data_t head_data;
	buf_pkg::thr_t thr;
	logic pop;
	logic overflow;

	// the stream goes straight into the write port.
	sync_fifo u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.write_en_i(in_valid_i),
		.write_data_i(in_data_i),
		.read_en_i(pop),
		.thr_i(thr),
		.read_data_o(head_data),
		.flags_o(flags),
		.count_o(count),
		.overflow_o(overflow)
	);

	buf_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wb_req_i(wb_req_i),
		.wb_rsp_o(wb_rsp_o),
		.flags_i(flags),
		.count_i(count),
		.head_data_i(head_data),
		.overflow_i(overflow),
		.thr_o(thr),
		.pop_o(pop),
		.irq_o(irq_o)
	);

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fifo_settings.svh"

module sync_fifo (
	input wire clk,
	input wire rst_n,

	input wire write_en_i,
	input wire buf_pkg::data_t write_data_i,

	input wire read_en_i,
	input wire buf_pkg::thr_t thr_i,

	output buf_pkg::data_t read_data_o,
	output buf_pkg::fifo_flags_t flags_o,
	output buf_pkg::count_t count_o,
	output logic overflow_o
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`FIFO_DEPTH - 1);
	localparam buf_pkg::count_t DEPTH_CNT = buf_pkg::count_t'(`FIFO_DEPTH);

	buf_pkg::data_t mem [`FIFO_DEPTH];

	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] head_next;
	logic [PTR_W-1:0] tail_q;
	logic [PTR_W-1:0] tail_next;

	buf_pkg::count_t count_q;
	buf_pkg::count_t count_next;
	buf_pkg::fifo_flags_t flags_q;

	logic do_write;
	logic do_read;

	// full and empty are only tested here.
	assign do_write = write_en_i & ~flags_q.full;
	assign do_read = read_en_i & ~flags_q.empty;

	// a rejected write is reported in the cycle it is attempted.
	assign overflow_o = write_en_i & flags_q.full;

	always_comb begin
		head_next = head_q;
		tail_next = tail_q;
		count_next = count_q;

		if (do_read) begin
			if (head_q == LAST_PTR) begin
				head_next = '0;
			end else begin
				head_next = head_q + 1'b1;
			end
		end

		if (do_write) begin
			if (tail_q == LAST_PTR) begin
				tail_next = '0;
			end else begin
				tail_next = tail_q + 1'b1;
			end
		end

		// simultaneous write and pop leaves the count alone.
		if (do_write && !do_read) begin
			count_next = count_q + 1'b1;
		end else if (!do_write && do_read) begin
			count_next = count_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[tail_q] <= write_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			flags_q.full <= 1'b0;
			flags_q.a_full <= 1'b0;
			flags_q.empty <= 1'b1;
			flags_q.a_empty <= 1'b1;
		end else begin
			head_q <= head_next;
			tail_q <= tail_next;
			count_q <= count_next;
			// flags follow the next count so they line up with it.
			flags_q.full <= (count_next == DEPTH_CNT);
			flags_q.a_full <= (count_next >= thr_i.a_full_thr);
			flags_q.empty <= (count_next == '0);
			flags_q.a_empty <= (count_next <= thr_i.a_empty_thr);
		end
	end

	// head byte is visible without a read strobe.
	assign read_data_o = mem[head_q];
	assign flags_o = flags_q;
	assign count_o = count_q;

	count_bounded: assert property (
		@(posedge clk) disable iff (!rst_n)
		count_q <= DEPTH_CNT
	) else $error("sync_fifo: count %0d above depth", count_q);

	full_empty_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(flags_q.full && flags_q.empty)
	) else $error("sync_fifo: full and empty both set");

endmodule

`default_nettype wire

/* tb_rx_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fifo_settings.svh"

module tb_rx_buffer;

	typedef enum logic [1:0] {
		step_push,
		step_write,
		step_read
	} step_kind_e;

	typedef struct packed {
		step_kind_e kind;
		logic [3:0] test;
		buf_pkg::wb_adr_t adr;
		buf_pkg::wb_dat_t dat;
		buf_pkg::wb_dat_t exp;
		buf_pkg::wb_dat_t mask;
		logic exp_irq;
	} step_t;

	localparam int MAX_STEPS = 200;

	logic clk;
	logic rst_n;
	logic in_valid;
	buf_pkg::data_t in_data;
	buf_pkg::wb_req_t wb_req;
	buf_pkg::wb_rsp_t wb_rsp;
	logic irq;

	step_t steps [MAX_STEPS];
	int n_steps;
	int build_test;
	int cur_step;
	int seed;
	int cycles;
	int cycle_limit;
	int test_errors;
	int error_count;
	int pass_count;
	int fail_count;
	string test_names [7];

	// reference model of the buffer that advances while the table is built.
	buf_pkg::data_t ref_q [$];
	buf_pkg::count_t ref_af;
	buf_pkg::count_t ref_ae;
	logic ref_ovf;
	logic [7:0] ref_drops;
	logic [2:0] ref_en;

	rx_buffer_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid_i(in_valid),
		.in_data_i(in_data),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.irq_o(irq)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the test table did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic buf_pkg::wb_dat_t status_word();
		buf_pkg::wb_dat_t w;
		buf_pkg::count_t cnt;
		cnt = buf_pkg::count_t'(ref_q.size());
		w = '0;
		w[3] = (ref_q.size() == `FIFO_DEPTH);
		w[2] = (cnt >= ref_af);
		w[1] = (ref_q.size() == 0);
		w[0] = (cnt <= ref_ae);
		w[4] = ref_ovf;
		w[11:8] = cnt;
		w[23:16] = ref_drops;
		return w;
	endfunction

	function automatic logic expected_irq();
		buf_pkg::count_t cnt;
		cnt = buf_pkg::count_t'(ref_q.size());
		return (ref_en[0] && ref_q.size() != 0) || (ref_en[1] && cnt >= ref_af) ||
			(ref_en[2] && ref_ovf);
	endfunction

	function automatic void add_step(step_kind_e kind, buf_pkg::wb_adr_t adr,
			buf_pkg::wb_dat_t dat, buf_pkg::wb_dat_t exp, buf_pkg::wb_dat_t mask);
		step_t s;
		s.kind = kind;
		s.test = 4'(build_test);
		s.adr = adr;
		s.dat = dat;
		s.exp = exp;
		s.mask = mask;
		s.exp_irq = expected_irq();
		steps[n_steps] = s;
		n_steps = n_steps + 1;
	endfunction

	// a byte that meets a full buffer is dropped and counted.
	function automatic void model_push(buf_pkg::data_t b);
		if (ref_q.size() < `FIFO_DEPTH) begin
			ref_q.push_back(b);
		end else begin
			ref_ovf = 1'b1;
			if (ref_drops != 8'hff) begin
				ref_drops = ref_drops + 8'd1;
			end
		end
		add_step(step_push, '0, {24'h0, b}, '0, '0);
	endfunction

	function automatic void model_read(buf_pkg::wb_adr_t adr);
		buf_pkg::wb_dat_t exp;
		buf_pkg::wb_dat_t mask;
		exp = '0;
		mask = '1;
		case (adr)
			`REG_DATA: begin
				if (ref_q.size() > 0) begin
					exp[7:0] = ref_q.pop_front();
				end else begin
					mask = '0;
				end
			end
			`REG_STATUS: exp = status_word();
			`REG_THRESH: begin
				exp[3:0] = ref_af;
				exp[11:8] = ref_ae;
			end
			default: exp[2:0] = ref_en;
		endcase
		add_step(step_read, adr, '0, exp, mask);
	endfunction

	function automatic void model_write(buf_pkg::wb_adr_t adr, buf_pkg::wb_dat_t dat);
		if (adr == `REG_THRESH) begin
			ref_af = dat[3:0];
			ref_ae = dat[11:8];
		end else if (adr == `REG_IRQ_EN) begin
			ref_en = dat[2:0];
		end else if (adr == `REG_STATUS && dat[4]) begin
			ref_ovf = 1'b0;
			ref_drops = '0;
		end
		add_step(step_write, adr, dat, '0, '0);
	endfunction

	task automatic push_byte(input buf_pkg::data_t b);
		in_valid = 1'b1;
		in_data = b;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// one classic cycle with the request held through the edge that samples ack.
	task automatic bus_cycle(input logic we, input buf_pkg::wb_adr_t adr,
			input buf_pkg::wb_dat_t dat, output buf_pkg::wb_dat_t rdat);
		int waits;
		waits = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		do begin
			@(negedge clk);
			waits = waits + 1;
		end while (!wb_rsp.ack);
		rdat = wb_rsp.dat;
		// ack is due one cycle after the request is sampled.
		check_value("wb_rsp_o.ack cycles", 32'(waits), 32'd1);
		@(negedge clk);
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
		check_value("wb_rsp_o.ack", {31'h0, wb_rsp.ack}, 32'h0);
	endtask

	task automatic check_value(input string name, input buf_pkg::wb_dat_t got,
			input buf_pkg::wb_dat_t exp);
		if (got !== exp) begin
			$display("Error: %s = 0x%08h, expected 0x%08h at step %0d", name, got, exp, cur_step);
			test_errors = test_errors + 1;
			error_count = error_count + 1;
		end
	endtask

	task automatic report_test(input logic [3:0] test);
		if (test_errors == 0) begin
			$display("test %0d %s: ok", test, test_names[test]);
			pass_count = pass_count + 1;
		end else begin
			$display("test %0d %s: %0d mismatches", test, test_names[test], test_errors);
			fail_count = fail_count + 1;
		end
		test_errors = 0;
	endtask

	initial begin
		buf_pkg::data_t b;
		buf_pkg::wb_dat_t rdat;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		wb_req = '0;
		cycles = 0;
		cycle_limit = 100;
		n_steps = 0;
		test_errors = 0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		seed = 32'h4ab4_de4c;
		test_names = '{"", "reset state", "order and count", "default thresholds",
			"programmed thresholds", "overflow", "interrupt"};
		ref_af = buf_pkg::count_t'(`FIFO_A_FULL_THR_DEF);
		ref_ae = buf_pkg::count_t'(`FIFO_A_EMPTY_THR_DEF);
		ref_ovf = 1'b0;
		ref_drops = '0;
		ref_en = '0;

		build_test = 1;
		model_read(`REG_STATUS);
		model_read(`REG_THRESH);
		model_read(`REG_IRQ_EN);

		build_test = 2;
		for (int k = 0; k < 5; k++) begin
			b = buf_pkg::data_t'($random(seed));
			model_push(b);
		end
		model_read(`REG_STATUS);
		for (int k = 0; k < 5; k++) model_read(`REG_DATA);
		model_read(`REG_STATUS);

		// flags are read back after every push and then the buffer is drained.
		for (int t = 3; t <= 4; t++) begin
			build_test = t;
			if (t == 4) begin
				model_write(`REG_THRESH, 32'h0000_0104);
				model_read(`REG_THRESH);
			end
			for (int k = 0; k < `FIFO_DEPTH; k++) begin
				b = buf_pkg::data_t'($random(seed));
				model_push(b);
				model_read(`REG_STATUS);
			end
			for (int k = 0; k < `FIFO_DEPTH; k++) model_read(`REG_DATA);
		end
		model_write(`REG_THRESH, 32'h0000_0206);

		build_test = 5;
		for (int k = 0; k < `FIFO_DEPTH + 3; k++) begin
			b = buf_pkg::data_t'($random(seed));
			model_push(b);
		end
		model_read(`REG_STATUS);
		for (int k = 0; k < `FIFO_DEPTH; k++) model_read(`REG_DATA);
		model_write(`REG_STATUS, 32'h0000_0010);
		model_read(`REG_STATUS);

		build_test = 6;
		model_write(`REG_IRQ_EN, 32'h0000_0001);
		model_push(buf_pkg::data_t'($random(seed)));
		model_read(`REG_DATA);
		model_write(`REG_IRQ_EN, 32'h0000_0002);
		for (int k = 0; k < 6; k++) model_push(buf_pkg::data_t'($random(seed)));
		for (int k = 0; k < 6; k++) model_read(`REG_DATA);
		model_write(`REG_IRQ_EN, 32'h0000_0004);
		for (int k = 0; k < `FIFO_DEPTH + 1; k++) begin
			model_push(buf_pkg::data_t'($random(seed)));
		end
		model_write(`REG_STATUS, 32'h0000_0010);
		for (int k = 0; k < `FIFO_DEPTH; k++) model_read(`REG_DATA);

		cycle_limit = n_steps * 10 + 100;

		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		for (int i = 0; i < n_steps; i++) begin
			cur_step = i;
			case (steps[i].kind)
				step_push: begin
					push_byte(steps[i].dat[7:0]);
					// irq_o lags the write by one cycle.
					@(negedge clk);
				end
				step_write: bus_cycle(1'b1, steps[i].adr, steps[i].dat, rdat);
				default: begin
					bus_cycle(1'b0, steps[i].adr, '0, rdat);
					check_value("wb_rsp_o.dat", rdat & steps[i].mask,
						steps[i].exp & steps[i].mask);
				end
			endcase
			check_value("irq_o", {31'h0, irq}, {31'h0, steps[i].exp_irq});
			if (i == n_steps - 1 || steps[i + 1].test != steps[i].test) begin
				report_test(steps[i].test);
			end
		end

		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
